// File: src/mul_pkg.sv
/*
 * Shared widths, lane and credit counts,
 * and the micro-op codes of the multiply unit
 */
`default_nettype none

package mul_pkg;

  // Datapath and tag widths
  localparam int XLEN      = 32;
  localparam int OPX_BITS  = XLEN + 1;
  localparam int PROD_BITS = 2 * OPX_BITS;
  localparam int SEQ_BITS  = 5;
  localparam int REG_BITS  = 5;

  // ------------------------------
  // Lane structure
  localparam int NUM_LANES          = 4;
  localparam int LANE_IDX_BITS      = 2;
  localparam int STAGES             = 3;
  localparam int LANE_FIFO_DEPTH    = 2;
  localparam int LANE_FIFO_PTR_BITS = 1;
  localparam logic [LANE_IDX_BITS-1:0] LAST_LANE = LANE_IDX_BITS'(NUM_LANES - 1);
  localparam logic [LANE_FIFO_PTR_BITS-1:0] LAST_SLOT =
    LANE_FIFO_PTR_BITS'(LANE_FIFO_DEPTH - 1);

  // ------------------------------
  // Credits on both boundaries
  localparam int ISSUE_CREDITS  = NUM_LANES * LANE_FIFO_DEPTH;
  localparam int WB_CREDITS     = 4;
  localparam int WB_CREDIT_BITS = 3;
  localparam logic [WB_CREDIT_BITS-1:0] WB_CREDIT_RESET = WB_CREDIT_BITS'(WB_CREDITS);

  // Micro-op codes, RV32M multiplies only
  localparam int UOP_BITS = 2;
  localparam logic [UOP_BITS-1:0] UOP_MUL    = 2'd0;
  localparam logic [UOP_BITS-1:0] UOP_MULH   = 2'd1;
  localparam logic [UOP_BITS-1:0] UOP_MULHSU = 2'd2;
  localparam logic [UOP_BITS-1:0] UOP_MULHU  = 2'd3;

endpackage

`default_nettype wire

// File: src/mul_dispatch.sv
/*
 * Issue-side dispatcher: registers each issued op
 * and steers it to one lane in strict rotation
 */
`timescale 1ns/1ns
`default_nettype none

module mul_dispatch (
  input  logic                              clk,
  input  logic                              reset,
  // Issue port from decode
  input  logic                              issue_valid,
  input  logic [mul_pkg::UOP_BITS-1:0]      issue_uop,
  input  logic [mul_pkg::SEQ_BITS-1:0]      issue_seq,
  input  logic [mul_pkg::REG_BITS-1:0]      issue_waddr,
  input  logic [mul_pkg::XLEN-1:0]          issue_op1,
  input  logic [mul_pkg::XLEN-1:0]          issue_op2,
  // Shared op fields plus one valid bit per lane
  output logic [mul_pkg::NUM_LANES-1:0]     lane_valid,
  output logic [mul_pkg::UOP_BITS-1:0]      lane_uop,
  output logic [mul_pkg::SEQ_BITS-1:0]      lane_seq,
  output logic [mul_pkg::REG_BITS-1:0]      lane_waddr,
  output logic [mul_pkg::XLEN-1:0]          lane_op1,
  output logic [mul_pkg::XLEN-1:0]          lane_op2
);

  logic [mul_pkg::LANE_IDX_BITS-1:0] rot_ptr;
  logic [mul_pkg::NUM_LANES-1:0]     lane_sel;

  // ------------------------------
  // Lane select from rotation pointer

  // One-hot decode of the pointer
  always_comb begin
    for (int i = 0; i < mul_pkg::NUM_LANES; i++) begin
      lane_sel[i] = (int'(rot_ptr) == i);
    end
  end

  // Pointer moves one lane per issued op
  always_ff @(posedge clk) begin
    if (reset) begin
      rot_ptr <= '0;
    end else if (issue_valid) begin
      if (rot_ptr == mul_pkg::LAST_LANE) begin
        rot_ptr <= '0;
      end else begin
        rot_ptr <= rot_ptr + 1'b1;
      end
    end
  end

  // ------------------------------
  // Op register, one cycle after issue

  // Valid bits are control state
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_valid <= '0;
    end else begin
      lane_valid <= issue_valid ? lane_sel : '0;
    end
  end

  // Payload only loads on issue
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      lane_uop   <= issue_uop;
      lane_seq   <= issue_seq;
      lane_waddr <= issue_waddr;
      lane_op1   <= issue_op1;
      lane_op2   <= issue_op2;
    end
  end

endmodule

`default_nettype wire

// File: src/mul_lane.sv
/*
 * One multiplier lane: 33x33 signed product over
 * STAGES registers with its tags, then an output FIFO
 */
`timescale 1ns/1ns
`default_nettype none

module mul_lane (
  input  logic                              clk,
  input  logic                              reset,
  // Op from the dispatcher
  input  logic                              in_valid,
  input  logic [mul_pkg::UOP_BITS-1:0]      in_uop,
  input  logic [mul_pkg::SEQ_BITS-1:0]      in_seq,
  input  logic [mul_pkg::REG_BITS-1:0]      in_waddr,
  input  logic [mul_pkg::XLEN-1:0]          in_op1,
  input  logic [mul_pkg::XLEN-1:0]          in_op2,
  // FIFO head toward the collector
  output logic                              out_ready,
  output logic [mul_pkg::SEQ_BITS-1:0]      out_seq,
  output logic [mul_pkg::REG_BITS-1:0]      out_waddr,
  output logic [mul_pkg::XLEN-1:0]          out_wdata,
  input  logic                              pop
);

  localparam int PD = mul_pkg::STAGES - 2;

  logic                                    sign_a;
  logic                                    sign_b;
  logic                                    s0_valid;
  logic                                    s0_hi;
  logic [mul_pkg::SEQ_BITS-1:0]            s0_seq;
  logic [mul_pkg::REG_BITS-1:0]            s0_waddr;
  logic [mul_pkg::OPX_BITS-1:0]            s0_a;
  logic [mul_pkg::OPX_BITS-1:0]            s0_b;
  logic signed [mul_pkg::PROD_BITS-1:0]    prod;
  logic                                    p_valid [PD];
  logic                                    p_hi    [PD];
  logic [mul_pkg::SEQ_BITS-1:0]            p_seq   [PD];
  logic [mul_pkg::REG_BITS-1:0]            p_waddr [PD];
  logic [mul_pkg::PROD_BITS-1:0]           p_prod  [PD];
  logic [mul_pkg::XLEN-1:0]                result;
  logic [mul_pkg::SEQ_BITS-1:0]            fifo_seq   [mul_pkg::LANE_FIFO_DEPTH];
  logic [mul_pkg::REG_BITS-1:0]            fifo_waddr [mul_pkg::LANE_FIFO_DEPTH];
  logic [mul_pkg::XLEN-1:0]                fifo_wdata [mul_pkg::LANE_FIFO_DEPTH];
  logic [mul_pkg::LANE_FIFO_PTR_BITS-1:0]  wr_ptr;
  logic [mul_pkg::LANE_FIFO_PTR_BITS-1:0]  rd_ptr;
  logic [mul_pkg::LANE_FIFO_PTR_BITS:0]    count;

  // ------------------------------
  // Stage 0: operand extension

  // MULH signs both, MULHSU only op1
  assign sign_a = (in_uop == mul_pkg::UOP_MULH) || (in_uop == mul_pkg::UOP_MULHSU);
  assign sign_b = (in_uop == mul_pkg::UOP_MULH);

  always_ff @(posedge clk) begin
    if (reset) begin
      s0_valid <= 1'b0;
    end else begin
      s0_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    s0_a     <= {sign_a & in_op1[mul_pkg::XLEN-1], in_op1};
    s0_b     <= {sign_b & in_op2[mul_pkg::XLEN-1], in_op2};
    s0_hi    <= (in_uop != mul_pkg::UOP_MUL);
    s0_seq   <= in_seq;
    s0_waddr <= in_waddr;
  end

  // ------------------------------
  // Product stages, tags alongside
  assign prod = $signed(s0_a) * $signed(s0_b);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < PD; k++) p_valid[k] <= 1'b0;
    end else begin
      p_valid[0] <= s0_valid;
      for (int k = 1; k < PD; k++) p_valid[k] <= p_valid[k-1];
    end
  end

  always_ff @(posedge clk) begin
    p_prod[0]  <= prod;
    p_hi[0]    <= s0_hi;
    p_seq[0]   <= s0_seq;
    p_waddr[0] <= s0_waddr;
    for (int k = 1; k < PD; k++) begin
      p_prod[k]  <= p_prod[k-1];
      p_hi[k]    <= p_hi[k-1];
      p_seq[k]   <= p_seq[k-1];
      p_waddr[k] <= p_waddr[k-1];
    end
  end

  // Low word for MUL, high word otherwise
  assign result = p_hi[PD-1] ? p_prod[PD-1][2*mul_pkg::XLEN-1:mul_pkg::XLEN]
                             : p_prod[PD-1][mul_pkg::XLEN-1:0];

  // ------------------------------
  // Output FIFO, final register stage
  // Never full while the issue credits hold
  always_ff @(posedge clk) begin
    if (p_valid[PD-1]) begin
      fifo_seq[wr_ptr]   <= p_seq[PD-1];
      fifo_waddr[wr_ptr] <= p_waddr[PD-1];
      fifo_wdata[wr_ptr] <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (p_valid[PD-1]) wr_ptr <= (wr_ptr == mul_pkg::LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == mul_pkg::LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      count <= count + p_valid[PD-1] - pop;
    end
  end

  assign out_ready = (count != '0);
  assign out_seq   = fifo_seq[rd_ptr];
  assign out_waddr = fifo_waddr[rd_ptr];
  assign out_wdata = fifo_wdata[rd_ptr];

endmodule

`default_nettype wire

// File: src/mul_collect.sv
/*
 * Writeback collector: drains lane FIFOs in issue
 * rotation and holds the writeback credit count
 */
`timescale 1ns/1ns
`default_nettype none

module mul_collect (
  input  logic                               clk,
  input  logic                               reset,
  // Lane FIFO heads
  input  logic [mul_pkg::NUM_LANES-1:0]      lane_ready,
  input  logic [mul_pkg::SEQ_BITS-1:0]       lane_seq   [mul_pkg::NUM_LANES],
  input  logic [mul_pkg::REG_BITS-1:0]       lane_waddr [mul_pkg::NUM_LANES],
  input  logic [mul_pkg::XLEN-1:0]           lane_wdata [mul_pkg::NUM_LANES],
  output logic [mul_pkg::NUM_LANES-1:0]      lane_pop,
  // Writeback port
  output logic                               wb_valid,
  output logic [mul_pkg::SEQ_BITS-1:0]       wb_seq,
  output logic [mul_pkg::REG_BITS-1:0]       wb_waddr,
  output logic [mul_pkg::XLEN-1:0]           wb_wdata,
  output logic                               wb_wen,
  input  logic                               wb_credit,
  // Credit back to the issuer
  output logic                               issue_credit
);

  logic [mul_pkg::LANE_IDX_BITS-1:0]  rot_ptr;
  logic [mul_pkg::WB_CREDIT_BITS-1:0] wb_cnt;
  logic                               send;

  // ------------------------------
  // Send decision

  // Only the lane next in rotation is looked at
  assign send = lane_ready[rot_ptr] && (wb_cnt != '0);

  always_comb begin
    for (int i = 0; i < mul_pkg::NUM_LANES; i++) begin
      lane_pop[i] = send && (int'(rot_ptr) == i);
    end
  end

  // Combinational from the selected FIFO head
  assign wb_valid     = send;
  assign wb_seq       = lane_seq[rot_ptr];
  assign wb_waddr     = lane_waddr[rot_ptr];
  assign wb_wdata     = lane_wdata[rot_ptr];
  assign wb_wen       = (wb_waddr != '0);
  assign issue_credit = send;

  // ------------------------------
  // Rotation and credit state

  // Same rotation as the dispatcher, so order holds
  always_ff @(posedge clk) begin
    if (reset) begin
      rot_ptr <= '0;
    end else if (send) begin
      rot_ptr <= (rot_ptr == mul_pkg::LAST_LANE) ? '0 : rot_ptr + 1'b1;
    end
  end

  // Return and spend may land in one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_cnt <= mul_pkg::WB_CREDIT_RESET;
    end else begin
      case ({wb_credit, send})
        2'b10:   wb_cnt <= wb_cnt + 1'b1;
        2'b01:   wb_cnt <= wb_cnt - 1'b1;
        default: wb_cnt <= wb_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/mul_unit.sv
/*
 * Multiply execute unit top: dispatcher,
 * multiplier lanes and writeback collector
 */
`timescale 1ns/1ns
`default_nettype none

module mul_unit (
  input  logic                              clk,
  input  logic                              reset,
  // Issue port
  input  logic                              issue_valid,
  input  logic [mul_pkg::UOP_BITS-1:0]      issue_uop,
  input  logic [mul_pkg::SEQ_BITS-1:0]      issue_seq,
  input  logic [mul_pkg::REG_BITS-1:0]      issue_waddr,
  input  logic [mul_pkg::XLEN-1:0]          issue_op1,
  input  logic [mul_pkg::XLEN-1:0]          issue_op2,
  output logic                              issue_credit,
  // Writeback port
  output logic                              wb_valid,
  output logic [mul_pkg::SEQ_BITS-1:0]      wb_seq,
  output logic [mul_pkg::REG_BITS-1:0]      wb_waddr,
  output logic [mul_pkg::XLEN-1:0]          wb_wdata,
  output logic                              wb_wen,
  input  logic                              wb_credit
);

  // Dispatcher to lanes
  logic [mul_pkg::NUM_LANES-1:0] d_valid;
  logic [mul_pkg::UOP_BITS-1:0]  d_uop;
  logic [mul_pkg::SEQ_BITS-1:0]  d_seq;
  logic [mul_pkg::REG_BITS-1:0]  d_waddr;
  logic [mul_pkg::XLEN-1:0]      d_op1;
  logic [mul_pkg::XLEN-1:0]      d_op2;

  // Lanes to collector
  logic [mul_pkg::NUM_LANES-1:0] l_ready;
  logic [mul_pkg::NUM_LANES-1:0] l_pop;
  logic [mul_pkg::SEQ_BITS-1:0]  l_seq   [mul_pkg::NUM_LANES];
  logic [mul_pkg::REG_BITS-1:0]  l_waddr [mul_pkg::NUM_LANES];
  logic [mul_pkg::XLEN-1:0]      l_wdata [mul_pkg::NUM_LANES];

  mul_dispatch i_dispatch (
    .clk, .reset,
    .issue_valid, .issue_uop, .issue_seq, .issue_waddr, .issue_op1, .issue_op2,
    .lane_valid (d_valid), .lane_uop (d_uop), .lane_seq (d_seq),
    .lane_waddr (d_waddr), .lane_op1 (d_op1), .lane_op2 (d_op2)
  );

  // Identical lanes sharing the op fields
  for (genvar g = 0; g < mul_pkg::NUM_LANES; g++) begin : gen_lane
    mul_lane i_lane (
      .clk, .reset,
      .in_valid (d_valid[g]), .in_uop (d_uop), .in_seq (d_seq),
      .in_waddr (d_waddr), .in_op1 (d_op1), .in_op2 (d_op2),
      .out_ready (l_ready[g]), .out_seq (l_seq[g]), .out_waddr (l_waddr[g]),
      .out_wdata (l_wdata[g]), .pop (l_pop[g])
    );
  end

  mul_collect i_collect (
    .clk, .reset,
    .lane_ready (l_ready), .lane_seq (l_seq), .lane_waddr (l_waddr),
    .lane_wdata (l_wdata), .lane_pop (l_pop),
    .wb_valid, .wb_seq, .wb_waddr, .wb_wdata, .wb_wen, .wb_credit,
    .issue_credit
  );

endmodule

`default_nettype wire

// File: tb/mul_unit_assertions.sv
/*
 * Concurrent checks on the mul_unit ports,
 * bound into the unit
 */
`timescale 1ns/1ns
`default_nettype none

module mul_unit_assertions (
  input logic                         clk,
  input logic                         reset,
  input logic                         issue_credit,
  input logic                         wb_valid,
  input logic [mul_pkg::SEQ_BITS-1:0] wb_seq,
  input logic [mul_pkg::REG_BITS-1:0] wb_waddr,
  input logic [mul_pkg::XLEN-1:0]     wb_wdata,
  input logic                         wb_credit
);

  // Sends that writeback has not yet paid back
  int outstanding;
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(wb_valid) - int'(wb_credit);
    end
  end

  // ------------------------------
  // Outputs quiet through reset
  a_reset_quiet: assert property (@(posedge clk) reset |=> !wb_valid && !issue_credit)
    else begin fail_count++; $error("wb_valid or issue_credit high during reset"); end

  // Never more sends in flight than writeback credits
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    outstanding + int'(wb_valid) <= mul_pkg::WB_CREDITS)
    else begin fail_count++; $error("writeback sent without a credit"); end

  a_known: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> !$isunknown({wb_seq, wb_waddr, wb_wdata}))
    else begin fail_count++; $error("unknown writeback fields"); end

endmodule

bind mul_unit mul_unit_assertions i_assertions (.*);

`default_nettype wire

// File: tb/mul_unit_tb.sv
/*
 * Testbench for mul_unit: pattern-driven issue under credits,
 * in-order scoreboard, latency, back-pressure and burst tests
 */
`timescale 1ns/1ns
`default_nettype none

module mul_unit_tb;

  localparam int NUM_PATTERNS    = 28;
  localparam int WATCHDOG_CYCLES = NUM_PATTERNS * 40 + 2000;
  localparam int LATENCY         = mul_pkg::STAGES + 1;

  logic                         clk;
  logic                         reset;
  logic                         issue_valid;
  logic [mul_pkg::UOP_BITS-1:0] issue_uop;
  logic [mul_pkg::SEQ_BITS-1:0] issue_seq;
  logic [mul_pkg::REG_BITS-1:0] issue_waddr;
  logic [31:0]                  issue_op1;
  logic [31:0]                  issue_op2;
  logic                         issue_credit;
  logic                         wb_valid;
  logic [mul_pkg::SEQ_BITS-1:0] wb_seq;
  logic [mul_pkg::REG_BITS-1:0] wb_waddr;
  logic [31:0]                  wb_wdata;
  logic                         wb_wen;
  logic                         wb_credit;

  // Five words per pattern: test, uop, op1, op2, expected
  logic [31:0] pat [NUM_PATTERNS*5];
  // Scoreboard in issue order; issue cycle is -1 when latency is not timed
  logic [31:0] exp_data_q [$];
  logic [9:0]  exp_tag_q [$];
  int          exp_cycle_q [$];
  // Cycles at which owed wb_credit pulses fall due
  int          due_q [$];
  logic [31:0] rng = 32'h27f4a1b5;
  logic [4:0]  next_seq;
  logic [4:0]  next_waddr;
  int          cycle;
  int          errors;
  int          checks;
  int          results;
  int          regained;
  int          credits;
  int          held;
  int          stalls;
  bit          wb_hold;

  mul_unit i_dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Xorshift step, result below range
  function automatic int next_random(input int range);
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return int'(rng % 32'(range));
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  // All driving happens 2 ns after the rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  // ------------------------------
  // Issue side

  task automatic issue_op(input int idx, input bit timed);
    // Issuer only raises valid while it holds a credit
    while (credits == 0) begin
      stalls++;
      wait_cycle();
    end
    issue_valid = 1'b1;
    issue_uop   = pat[5*idx+1][1:0];
    issue_seq   = next_seq;
    issue_waddr = next_waddr;
    issue_op1   = pat[5*idx+2];
    issue_op2   = pat[5*idx+3];
    exp_data_q.push_back(pat[5*idx+4]);
    exp_tag_q.push_back({next_seq, next_waddr});
    exp_cycle_q.push_back(timed ? cycle : -1);
    credits--;
    next_seq++;
    next_waddr++;
    wait_cycle();
    issue_valid = 1'b0;
  endtask

  // Every pattern of one test, random gaps up to max_gap-1
  task automatic issue_test(input int t, input int max_gap, input bit timed, output int n);
    n = 0;
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      if (pat[5*i] == 32'(t)) begin
        if (max_gap > 0) repeat (next_random(max_gap)) wait_cycle();
        issue_op(i, timed);
        n++;
      end
    end
  endtask

  // No op in flight and every owed credit handed back
  task automatic wait_idle();
    while (exp_data_q.size() != 0 || due_q.size() != 0 || held != 0) wait_cycle();
    repeat (2) wait_cycle();
  endtask

  // ------------------------------
  // Writeback side

  task automatic collect_result();
    logic [31:0] data;
    logic [9:0]  tag;
    int          t0;
    if (exp_data_q.size() == 0) begin
      errors++;
      $display("Writeback result in cycle %0d with no op outstanding", cycle);
    end else begin
      data = exp_data_q.pop_front();
      tag  = exp_tag_q.pop_front();
      t0   = exp_cycle_q.pop_front();
      check_value("wb_wdata", wb_wdata, data);
      check_value("wb_seq", 32'(wb_seq), 32'(tag[9:5]));
      check_value("wb_waddr", 32'(wb_waddr), 32'(tag[4:0]));
      check_value("wb_wen", 32'(wb_wen), 32'(tag[4:0] != 5'd0));
      if (t0 >= 0) check_value("wb_valid latency", 32'(cycle - t0), 32'(LATENCY));
      results++;
      if (wb_hold) held++;
      else due_q.push_back(cycle + 1 + next_random(4));
    end
  endtask

  // Sampled at the falling edge, where the combinational outputs are settled
  always @(negedge clk) begin
    if (!reset) begin
      if (issue_credit !== wb_valid) begin
        errors++;
        $display("issue_credit and wb_valid disagree in cycle %0d", cycle);
      end
      if (issue_credit) begin
        credits++;
        regained++;
      end
      if (wb_valid) collect_result();
    end
  end

  // One owed writeback credit per cycle once due
  always @(posedge clk) begin
    #2;
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      wb_credit = 1'b1;
      void'(due_q.pop_front());
    end else begin
      wb_credit = 1'b0;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles with results still missing", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int n;
    int err0;
    int res0;
    clk         = 1'b0;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_uop   = '0;
    issue_seq   = '0;
    issue_waddr = '0;
    issue_op1   = '0;
    issue_op2   = '0;
    wb_credit   = 1'b0;
    next_seq    = 5'd16;
    next_waddr  = 5'd0;
    credits     = mul_pkg::ISSUE_CREDITS;
    $readmemh("tb/mul_patterns.hex", pat);
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      if (pat[5*i] < 1 || pat[5*i] > 4 || pat[5*i+1] > 32'(mul_pkg::UOP_MULHU)) begin
        errors++;
        $display("Pattern %0d has a bad test number or uop", i);
      end
    end
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;

    // Single op into the idle unit, latency timed
    err0 = errors;
    issue_test(1, 0, 1'b1, n);
    wait_idle();
    $display("Test 1 latency: %0d ops, %0d errors", n, errors - err0);

    err0 = errors;
    issue_test(2, 3, 1'b0, n);
    wait_idle();
    $display("Test 2 arithmetic stream: %0d ops, %0d errors", n, errors - err0);

    // Withhold writeback credits, then return them
    err0 = errors;
    res0 = results;
    wb_hold = 1'b1;
    issue_test(3, 0, 1'b0, n);
    repeat (20) wait_cycle();
    check_value("results under back-pressure", 32'(results - res0), 32'(mul_pkg::WB_CREDITS));
    check_value("issuer credits under back-pressure", 32'(credits),
                32'(mul_pkg::ISSUE_CREDITS - n + mul_pkg::WB_CREDITS));
    wb_hold = 1'b0;
    for (int i = 0; i < held; i++) due_q.push_back(cycle + 1 + i);
    held = 0;
    wait_idle();
    $display("Test 3 writeback back-pressure: %0d ops, %0d errors", n, errors - err0);

    err0 = errors;
    stalls = 0;
    issue_test(4, 0, 1'b0, n);
    wait_idle();
    check_value("burst stall cycles", 32'(stalls), 32'(0));
    $display("Test 4 issue credit burst: %0d ops, %0d errors", n, errors - err0);

    check_value("results received", 32'(results), 32'(NUM_PATTERNS));
    check_value("credits regained", 32'(regained), 32'(results));
    check_value("issuer credits at end", 32'(credits), 32'(mul_pkg::ISSUE_CREDITS));
    errors = errors + i_dut.i_assertions.fail_count;
    $display("4 tests, %0d results, %0d checks, %0d errors", results, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/mul_pkg.sv
src/mul_dispatch.sv
src/mul_lane.sv
src/mul_collect.sv
src/mul_unit.sv
tb/mul_unit_assertions.sv
tb/mul_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mul_unit_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/mul_patterns.hex
// Columns: test, uop (0 MUL, 1 MULH, 2 MULHSU, 3 MULHU), op1, op2, expected result
// Tests: 1 latency, 2 random stream, 3 writeback back-pressure, 4 issue burst
1 0 00000003 fffffffe fffffffa
2 0 7fffffff 7fffffff 00000001
2 1 7fffffff 7fffffff 3fffffff
2 1 80000000 80000000 40000000
2 2 80000000 80000000 c0000000
2 3 ffffffff ffffffff fffffffe
2 2 ffffffff ffffffff ffffffff
2 1 ffffffff ffffffff 00000000
2 3 80000000 ffffffff 7fffffff
2 2 80000000 ffffffff 80000000
2 1 7fffffff 80000000 c0000000
2 0 00000001 ffffffff ffffffff
3 1 00000001 ffffffff ffffffff
3 3 00000001 ffffffff 00000000
3 2 00000001 ffffffff 00000000
3 2 ffffffff 00000001 ffffffff
3 0 00000000 80000000 00000000
3 1 00000000 ffffffff 00000000
3 0 0000ffff 0000ffff fffe0001
3 3 00010000 00010000 00000001
4 0 00001000 00002000 02000000
4 1 ffff0000 00010000 ffffffff
4 3 ffff0000 00010000 0000ffff
4 1 00000003 fffffffe ffffffff
4 3 00000003 fffffffe 00000002
4 2 fffffffe 00000003 ffffffff
4 1 80000000 00000001 ffffffff
4 0 80000000 ffffffff 80000000
